// ==== verilog/s16b_settings.svh ====
//----------------------------------------
// System 16B bus glue settings
// Widths, address fields and idle values
//----------------------------------------
`ifndef S16B_SETTINGS_SVH
`define S16B_SETTINGS_SVH

// Bus widths
`define S16B_ADDR_W       23   // CPU word address, bits 23:1
`define S16B_DATA_W       16
`define S16B_ROM_ADDR_W   18   // ROM word address

// Address fields
`define S16B_REGION_LSB   20   // Three bit region field, 1MB each
`define S16B_TEXT_SEL_BIT 16   // Text RAM vs tile RAM in region 5
`define S16B_IO_GROUP_LSB 12   // Two bit I/O group field

// Data values
`define S16B_BUS_IDLE     {`S16B_DATA_W{1'b1}}

// Video control
`define S16B_TBANK_W      6

`endif

// ==== verilog/s16b_pkg.sv ====
//----------------------------------------
// System 16B shared types
// Bus regions, I/O groups, boards, games
//----------------------------------------
package s16b_pkg;

    // One region per megabyte of CPU space
    typedef enum logic [2:0] {
        REGION_ROM0  = 3'd0,
        REGION_ROM1  = 3'd1,
        REGION_ROM2  = 3'd2,
        REGION_RAM   = 3'd3,
        REGION_OBJ   = 3'd4,
        REGION_VIDEO = 3'd5,
        REGION_PAL   = 3'd6,
        REGION_IO    = 3'd7
    } bus_region_e;

    typedef enum logic [1:0] {
        IO_VIDEO_CTRL = 2'd0,
        IO_INPUTS     = 2'd1,
        IO_DIPS       = 2'd2,
        IO_CUSTOM     = 2'd3
    } io_group_e;

    // ROM board families
    typedef enum logic [1:0] {
        BOARD_5797,
        BOARD_5358,
        BOARD_KOREAN,
        BOARD_5521     // Also covers 5704
    } rom_board_e;

    typedef enum logic [7:0] {
        GAME_PASSSHT   = 8'h02,
        GAME_BULLET    = 8'h11,
        GAME_SDI       = 8'h12,
        GAME_PASSSHT_J = 8'h13,
        GAME_PASSSHT3  = 8'h18,
        GAME_DEFENSE   = 8'h19
    } game_e;

endpackage

// ==== verilog/s16b_region_decode.sv ====
//----------------------------------------
// System 16B region decoder
// Registered chip selects and the ROM
// word address map per board family
//----------------------------------------
`include "s16b_settings.svh"

module s16b_region_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  game_id,
    input  logic [`S16B_ADDR_W:1]       addr,
    input  logic                        as_n,
    input  logic                        uds_n,
    input  logic                        lds_n,
    input  logic                        rnw,
    output logic                        rom_cs,
    output logic                        ram_cs,
    output logic                        vram_cs,
    output logic                        char_cs,
    output logic                        objram_cs,
    output logic                        pal_cs,
    output logic                        io_cs,
    output logic                        tbank_cs,
    output logic [`S16B_ROM_ADDR_W-1:0] rom_addr
);

    s16b_pkg::bus_region_e region;
    s16b_pkg::rom_board_e  board;
    logic       rom_large;  // 5358 large variant
    logic [1:0] rom_idx;
    logic       is_rom;
    logic       ds_act;
    logic       text_sel;

    assign region   = s16b_pkg::bus_region_e'(addr[`S16B_REGION_LSB+2:`S16B_REGION_LSB]);
    assign is_rom   = region == s16b_pkg::REGION_ROM0 || region == s16b_pkg::REGION_ROM1
                   || region == s16b_pkg::REGION_ROM2;
    assign ds_act   = !uds_n || !lds_n;
    assign text_sel = addr[`S16B_TEXT_SEL_BIT];

    // Board family from the game id
    always_comb begin
        rom_large = game_id == 8'h10 || game_id == 8'h1a;
        if (game_id[7:5] == 3'b001)
            board = s16b_pkg::BOARD_5797;
        else if (game_id[7:4] == 4'b0001)
            board = s16b_pkg::BOARD_5358;
        else if (game_id[7:3] == 5'b00001)
            board = s16b_pkg::BOARD_KOREAN;
        else
            board = s16b_pkg::BOARD_5521;
    end

    always_comb begin
        case (region)
            s16b_pkg::REGION_ROM1: rom_idx = 2'd1;
            s16b_pkg::REGION_ROM2: rom_idx = 2'd2;
            default:               rom_idx = 2'd0;
        endcase
        case (board)
            s16b_pkg::BOARD_5797:   rom_addr = addr[18:1];
            s16b_pkg::BOARD_5358:
                if (rom_large)
                    rom_addr = {rom_idx, addr[16:1]};
                else
                    rom_addr = {1'b0, rom_idx, addr[15:1]};
            s16b_pkg::BOARD_KOREAN: rom_addr = {1'b0, addr[17:1]};
            default:                rom_addr = {rom_idx[0], addr[17:1]};  // 512kB
        endcase
    end

    // Selects follow the strobe, cleared between accesses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {rom_cs, ram_cs, vram_cs, char_cs} <= '0;
            {objram_cs, pal_cs, io_cs, tbank_cs} <= '0;
        end else begin
            rom_cs    <= !as_n && is_rom && rnw;
            ram_cs    <= !as_n && ds_act && region == s16b_pkg::REGION_RAM;
            vram_cs   <= !as_n && ds_act && region == s16b_pkg::REGION_VIDEO && !text_sel;
            char_cs   <= !as_n && region == s16b_pkg::REGION_VIDEO && text_sel;
            objram_cs <= !as_n && region == s16b_pkg::REGION_OBJ;
            pal_cs    <= !as_n && region == s16b_pkg::REGION_PAL;
            io_cs     <= !as_n && region == s16b_pkg::REGION_IO;
            tbank_cs  <= !as_n && region == s16b_pkg::REGION_ROM2 && !rnw;  // 5521/5704 only
        end
    end

endmodule

// ==== verilog/s16b_video_ctrl.sv ====
//----------------------------------------
// System 16B video control
// Flip, video enable and tile bank
//----------------------------------------
`include "s16b_settings.svh"

module s16b_video_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     io_cs,
    input  logic                     tbank_cs,
    input  logic [`S16B_ADDR_W:1]    addr,
    input  logic                     lds_n,
    input  logic                     rnw,
    input  logic [`S16B_DATA_W-1:0]  cpu_dout,
    output logic                     flip,
    output logic                     video_en,
    output logic [`S16B_TBANK_W-1:0] tile_bank
);

    localparam int HALF = `S16B_TBANK_W / 2;

    s16b_pkg::io_group_e group;
    logic                wr_lo;   // Low byte write

    assign group = s16b_pkg::io_group_e'(addr[`S16B_IO_GROUP_LSB+1:`S16B_IO_GROUP_LSB]);
    assign wr_lo = !lds_n && !rnw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            video_en  <= 1'b1;    // Screen on out of reset
            tile_bank <= '0;
        end else begin
            if (io_cs && wr_lo && group == s16b_pkg::IO_VIDEO_CTRL) begin
                flip     <= cpu_dout[6];
                video_en <= cpu_dout[5];
            end
            if (tbank_cs && wr_lo) begin
                if (addr[1])
                    tile_bank[`S16B_TBANK_W-1:HALF] <= cpu_dout[HALF-1:0];
                else
                    tile_bank[HALF-1:0] <= cpu_dout[HALF-1:0];
            end
        end
    end

endmodule

// ==== verilog/s16b_cab_io.sv ====
//----------------------------------------
// System 16B cabinet inputs
// Per-game joystick and button ordering
//----------------------------------------
`include "s16b_settings.svh"

module s16b_cab_io (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            game_id,
    input  logic                  io_cs,
    input  logic [`S16B_ADDR_W:1] addr,
    input  logic [7:0]            joystick1,
    input  logic [7:0]            joystick2,
    input  logic [7:0]            joystick3,
    input  logic [7:0]            joystick4,
    input  logic [15:0]           joyana1,
    input  logic [15:0]           joyana2,
    input  logic [15:0]           joyana3,
    input  logic [15:0]           joyana4,
    input  logic [3:0]            start_button,
    input  logic [3:0]            coin_input,
    input  logic                  service,
    input  logic                  dip_test,
    input  logic [7:0]            dipsw_a,
    input  logic [7:0]            dipsw_b,
    output logic [7:0]            cab_dout
);

    s16b_pkg::io_group_e group;
    logic       is_bullet;
    logic       is_passsht;
    logic       is_analog;     // SDI and Defense sticks
    logic [7:0] sel_joy;
    logic [7:0] sorted;
    logic [7:0] joy_byte;
    logic [7:0] cust_joy;
    logic [7:0] cust_ana;
    logic [7:0] cab_next;

    // Board wiring of the standard joystick ports
    function automatic logic [7:0] sort_joy(input logic [7:0] j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    assign group      = s16b_pkg::io_group_e'(addr[`S16B_IO_GROUP_LSB+1:`S16B_IO_GROUP_LSB]);
    assign is_bullet  = game_id == s16b_pkg::GAME_BULLET;
    assign is_passsht = game_id == s16b_pkg::GAME_PASSSHT || game_id == s16b_pkg::GAME_PASSSHT_J
                     || game_id == s16b_pkg::GAME_PASSSHT3;
    assign is_analog  = game_id == s16b_pkg::GAME_SDI || game_id == s16b_pkg::GAME_DEFENSE;

    always_comb begin
        case (addr[2:1])
            2'd2:    sel_joy = joystick3;
            2'd3:    sel_joy = joystick2;
            default: sel_joy = joystick1;
        endcase
        sorted   = sort_joy(sel_joy);
        joy_byte = is_bullet ? {sorted[3:0], sorted[7:4]} : sorted;
        case (addr[2:1])
            2'd0: begin
                cust_joy = joystick1;
                cust_ana = joyana1[15:8];
            end
            2'd1: begin
                cust_joy = joystick2;
                cust_ana = joyana2[15:8];
            end
            2'd2: begin
                cust_joy = joystick3;
                cust_ana = joyana3[15:8];
            end
            default: begin
                cust_joy = joystick4;
                cust_ana = joyana4[15:8];
            end
        endcase
    end

    always_comb begin
        cab_next = '1;
        if (io_cs) begin
            case (group)
                s16b_pkg::IO_INPUTS:
                    case (addr[2:1])
                        2'd0: begin
                            cab_next = {2'b11, start_button[1:0], service, dip_test,
                                        coin_input[1:0]};
                            if (is_bullet)
                                cab_next[7:6] = {coin_input[2], start_button[2]};
                            if (is_passsht)
                                cab_next[7:6] = start_button[3:2];
                        end
                        2'd2: if (is_bullet) cab_next = joy_byte;   // Third player
                        default: cab_next = joy_byte;
                    endcase
                s16b_pkg::IO_DIPS: cab_next = addr[1] ? dipsw_a : dipsw_b;
                s16b_pkg::IO_CUSTOM:
                    if (addr[9:8] == 2'b10) begin
                        if (game_id == s16b_pkg::GAME_PASSSHT_J)
                            cab_next = {cust_joy[7:4], cust_joy[1:0], cust_joy[3:2]};
                        else if (is_analog)
                            cab_next = cust_ana;
                    end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cab_dout <= '1;
        else
            cab_dout <= cab_next;
    end

endmodule

// ==== verilog/s16b_data_mux.sv ====
//----------------------------------------
// System 16B read data bus
// Holds its value on unmapped accesses
//----------------------------------------
`include "s16b_settings.svh"

module s16b_data_mux (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ram_cs,
    input  logic                    vram_cs,
    input  logic                    rom_cs,
    input  logic                    char_cs,
    input  logic                    pal_cs,
    input  logic                    objram_cs,
    input  logic                    io_cs,
    input  logic [`S16B_DATA_W-1:0] ram_data,   // Work RAM or tile RAM
    input  logic [`S16B_DATA_W-1:0] rom_data,
    input  logic [`S16B_DATA_W-1:0] char_dout,
    input  logic [`S16B_DATA_W-1:0] pal_dout,
    input  logic [`S16B_DATA_W-1:0] obj_dout,
    input  logic [7:0]              cab_dout,
    output logic [`S16B_DATA_W-1:0] cpu_din
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            cpu_din <= `S16B_BUS_IDLE;
        else if (ram_cs || vram_cs)
            cpu_din <= ram_data;
        else if (rom_cs)
            cpu_din <= rom_data;    // No decryption
        else if (char_cs)
            cpu_din <= char_dout;
        else if (pal_cs)
            cpu_din <= pal_dout;
        else if (objram_cs)
            cpu_din <= obj_dout;
        else if (io_cs)
            cpu_din <= {8'hff, cab_dout};   // Inputs are 8 bits wide
    end

endmodule

// ==== verilog/s16b_main_bus.sv ====
//----------------------------------------
// System 16B main board bus glue
// Decoder, video control, inputs, data bus
//----------------------------------------
`include "s16b_settings.svh"

module s16b_main_bus (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  game_id,
    input  logic [`S16B_ADDR_W:1]       addr,
    input  logic                        as_n,
    input  logic                        uds_n,
    input  logic                        lds_n,
    input  logic                        rnw,
    input  logic [`S16B_DATA_W-1:0]     cpu_dout,
    input  logic [`S16B_DATA_W-1:0]     ram_data,
    input  logic [`S16B_DATA_W-1:0]     rom_data,
    input  logic [`S16B_DATA_W-1:0]     char_dout,
    input  logic [`S16B_DATA_W-1:0]     pal_dout,
    input  logic [`S16B_DATA_W-1:0]     obj_dout,
    input  logic [7:0]                  joystick1,
    input  logic [7:0]                  joystick2,
    input  logic [7:0]                  joystick3,
    input  logic [7:0]                  joystick4,
    input  logic [15:0]                 joyana1,
    input  logic [15:0]                 joyana2,
    input  logic [15:0]                 joyana3,
    input  logic [15:0]                 joyana4,
    input  logic [3:0]                  start_button,
    input  logic [3:0]                  coin_input,
    input  logic                        service,
    input  logic                        dip_test,
    input  logic [7:0]                  dipsw_a,
    input  logic [7:0]                  dipsw_b,
    output logic [`S16B_DATA_W-1:0]     cpu_din,
    output logic [`S16B_ROM_ADDR_W-1:0] rom_addr,
    output logic                        rom_cs,
    output logic                        ram_cs,
    output logic                        vram_cs,
    output logic                        char_cs,
    output logic                        objram_cs,
    output logic                        pal_cs,
    output logic                        io_cs,
    output logic                        flip,
    output logic                        video_en,
    output logic [`S16B_TBANK_W-1:0]    tile_bank
);

    logic       tbank_cs;
    logic [7:0] cab_dout;

    s16b_region_decode i_region_decode (
        .clk(clk), .rst(rst), .game_id(game_id), .addr(addr),
        .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n), .rnw(rnw),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .objram_cs(objram_cs), .pal_cs(pal_cs), .io_cs(io_cs), .tbank_cs(tbank_cs),
        .rom_addr(rom_addr)
    );

    s16b_video_ctrl i_video_ctrl (
        .clk(clk), .rst(rst), .io_cs(io_cs), .tbank_cs(tbank_cs), .addr(addr),
        .lds_n(lds_n), .rnw(rnw), .cpu_dout(cpu_dout),
        .flip(flip), .video_en(video_en), .tile_bank(tile_bank)
    );

    s16b_cab_io i_cab_io (
        .clk(clk), .rst(rst), .game_id(game_id), .io_cs(io_cs), .addr(addr),
        .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4),
        .joyana1(joyana1), .joyana2(joyana2), .joyana3(joyana3), .joyana4(joyana4),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .cab_dout(cab_dout)
    );

    s16b_data_mux i_data_mux (
        .clk(clk), .rst(rst),
        .ram_cs(ram_cs), .vram_cs(vram_cs), .rom_cs(rom_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs),
        .ram_data(ram_data), .rom_data(rom_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .cab_dout(cab_dout),
        .cpu_din(cpu_din)
    );

endmodule

// ==== verification/s16b_props.sv ====
//----------------------------------------
// System 16B bus glue assertions
// Chip select rules and reset values
//----------------------------------------
module s16b_props (
    input logic clk,
    input logic rst,
    input logic as_n,
    input logic rnw,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs,
    input logic char_cs,
    input logic objram_cs,
    input logic pal_cs,
    input logic io_cs,
    input logic tbank_cs,
    input logic video_en
);

    logic [7:0] sel;

    assign sel = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, tbank_cs};

    a_one_select: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else $error("More than one chip select active: %b", sel);

    // Strobe released means no select on the next cycle
    a_idle_clear: assert property (@(posedge clk) disable iff (rst) as_n |=> sel == 8'h00)
        else $error("Chip select still active after the address strobe went high");

    a_rom_read: assert property (@(posedge clk) disable iff (rst) rom_cs |-> $past(rnw))
        else $error("ROM select raised for a write cycle");

    a_reset_video: assert property (@(posedge clk) $fell(rst) |-> video_en)
        else $error("Video enable low after reset");

endmodule

bind s16b_main_bus s16b_props i_props (
    .clk(clk), .rst(rst), .as_n(as_n), .rnw(rnw),
    .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
    .objram_cs(objram_cs), .pal_cs(pal_cs), .io_cs(io_cs), .tbank_cs(tbank_cs),
    .video_en(video_en)
);

// ==== verification/s16b_tb.sv ====
//----------------------------------------
// System 16B bus glue testbench
// Random bus accesses against a model
//----------------------------------------
`include "s16b_settings.svh"

module s16b_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int ACCESS_CYCLES = 7;    // Drive, 4 held, 2 idle
    localparam int N_MEM   = 40;
    localparam int N_ROM   = 36;
    localparam int N_FAM   = 12;
    localparam int N_WR    = 20;
    localparam int N_IO    = 48;
    localparam int N_UNMAP = 8;
    localparam int N_TOTAL = N_MEM + N_ROM + N_FAM + N_WR + N_IO + N_UNMAP + 1;

    typedef struct packed {
        logic [`S16B_DATA_W-1:0]     din;
        logic [`S16B_ROM_ADDR_W-1:0] raddr;
        logic [6:0]                  cs;     // rom ram vram char obj pal io
        logic                        flip;
        logic                        ven;
        logic [`S16B_TBANK_W-1:0]    tbank;
    } expect_t;

    logic clk = 1'b0;
    logic rst;
    logic [7:0] game_id;
    logic [`S16B_ADDR_W:1] addr;
    logic as_n, uds_n, lds_n, rnw;
    logic [`S16B_DATA_W-1:0] cpu_dout, ram_data, rom_data, char_dout, pal_dout, obj_dout;
    logic [7:0] joystick1, joystick2, joystick3, joystick4;
    logic [15:0] joyana1, joyana2, joyana3, joyana4;
    logic [3:0] start_button, coin_input;
    logic service, dip_test;
    logic [7:0] dipsw_a, dipsw_b;
    logic [`S16B_DATA_W-1:0] cpu_din;
    logic [`S16B_ROM_ADDR_W-1:0] rom_addr;
    logic rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs;
    logic flip, video_en;
    logic [`S16B_TBANK_W-1:0] tile_bank;

    expect_t model;     // Last known DUT state
    expect_t exp_r;
    logic    check_req = 1'b0;
    int      checks = 0;
    int      errors = 0;

    s16b_main_bus i_s16b_main_bus (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] sort_stick(input logic [7:0] j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    // Expected input byte for an I/O read
    function automatic logic [7:0] cab_model(input logic [`S16B_ADDR_W:1] a,
                                             input logic [7:0] game);
        logic [7:0]  r;
        logic [7:0]  s;
        logic [7:0]  pj;
        logic [15:0] pa;
        logic        bullet;
        bullet = game == s16b_pkg::GAME_BULLET;
        r = 8'hff;
        case (a[2:1])
            2'd1:    s = sort_stick(joystick1);
            2'd3:    s = sort_stick(joystick2);
            default: s = sort_stick(joystick3);
        endcase
        if (bullet)
            s = {s[3:0], s[7:4]};
        case (a[2:1])
            2'd0: begin
                pj = joystick1;
                pa = joyana1;
            end
            2'd1: begin
                pj = joystick2;
                pa = joyana2;
            end
            2'd2: begin
                pj = joystick3;
                pa = joyana3;
            end
            default: begin
                pj = joystick4;
                pa = joyana4;
            end
        endcase
        case (a[13:12])
            2'd1:
                if (a[2:1] == 2'd0) begin
                    r = {2'b11, start_button[1:0], service, dip_test, coin_input[1:0]};
                    if (bullet)
                        r[7:6] = {coin_input[2], start_button[2]};
                    if (game == s16b_pkg::GAME_PASSSHT || game == s16b_pkg::GAME_PASSSHT_J
                        || game == s16b_pkg::GAME_PASSSHT3)
                        r[7:6] = start_button[3:2];
                end else if (a[2:1] != 2'd2 || bullet) begin
                    r = s;
                end
            2'd2: r = a[1] ? dipsw_a : dipsw_b;
            2'd3:
                if (a[9:8] == 2'b10) begin
                    if (game == s16b_pkg::GAME_PASSSHT_J)
                        r = {pj[7:4], pj[1:0], pj[3:2]};
                    else if (game == s16b_pkg::GAME_SDI || game == s16b_pkg::GAME_DEFENSE)
                        r = pa[15:8];
                end
            default: ;
        endcase
        return r;
    endfunction

    // Full bus model, one held access
    function automatic expect_t ref_model(input logic [`S16B_ADDR_W:1] a, input logic asn,
                                          input logic rd, input logic udsn, input logic ldsn,
                                          input logic [7:0] game, input expect_t prev);
        expect_t    e;
        logic [2:0] reg_f;
        logic [1:0] ridx;
        logic       ds;
        e     = prev;
        reg_f = a[22:20];
        ds    = !udsn || !ldsn;
        ridx  = reg_f == 3'd1 ? 2'd1 : reg_f == 3'd2 ? 2'd2 : 2'd0;
        if (game[7:5] == 3'b001)
            e.raddr = a[18:1];
        else if (game == 8'h10 || game == 8'h1a)
            e.raddr = {ridx, a[16:1]};
        else if (game[7:4] == 4'b0001)
            e.raddr = {1'b0, ridx, a[15:1]};
        else if (game[7:3] == 5'b00001)
            e.raddr = {1'b0, a[17:1]};
        else
            e.raddr = {ridx[0], a[17:1]};
        e.cs = '0;
        if (!asn) begin
            e.cs[6] = reg_f <= 3'd2 && rd;
            e.cs[5] = reg_f == 3'd3 && ds;
            e.cs[4] = reg_f == 3'd5 && !a[16] && ds;
            e.cs[3] = reg_f == 3'd5 && a[16];
            e.cs[2] = reg_f == 3'd4;
            e.cs[1] = reg_f == 3'd6;
            e.cs[0] = reg_f == 3'd7;
        end
        if (e.cs[5] || e.cs[4])
            e.din = ram_data;
        else if (e.cs[6])
            e.din = rom_data;
        else if (e.cs[3])
            e.din = char_dout;
        else if (e.cs[1])
            e.din = pal_dout;
        else if (e.cs[2])
            e.din = obj_dout;
        else if (e.cs[0])
            e.din = {8'hff, cab_model(a, game)};
        if (!asn && !rd && !ldsn) begin  // Low byte write
            if (reg_f == 3'd7 && a[13:12] == 2'd0) begin
                e.flip = cpu_dout[6];
                e.ven  = cpu_dout[5];
            end
            if (reg_f == 3'd2) begin
                if (a[1])
                    e.tbank[5:3] = cpu_dout[2:0];
                else
                    e.tbank[2:0] = cpu_dout[2:0];
            end
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    always @(negedge clk) begin
        if (check_req) begin
            exp_r = ref_model(addr, as_n, rnw, uds_n, lds_n, game_id, model);
            check_value("cpu_din", 32'(cpu_din), 32'(exp_r.din));
            check_value("rom_addr", 32'(rom_addr), 32'(exp_r.raddr));
            check_value("chip_selects",
                        32'({rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs}),
                        32'(exp_r.cs));
            check_value("flip", 32'(flip), 32'(exp_r.flip));
            check_value("video_en", 32'(video_en), 32'(exp_r.ven));
            check_value("tile_bank", 32'(tile_bank), 32'(exp_r.tbank));
            model     = exp_r;
            check_req = 1'b0;
        end
    end

    function automatic logic [7:0] pick_game(input int unsigned n);
        case (n % 6)
            0:       return s16b_pkg::GAME_SDI;
            1:       return s16b_pkg::GAME_PASSSHT;
            2:       return s16b_pkg::GAME_BULLET;
            3:       return s16b_pkg::GAME_PASSSHT_J;
            4:       return s16b_pkg::GAME_PASSSHT3;
            default: return s16b_pkg::GAME_DEFENSE;
        endcase
    endfunction

    // Data strobes as {uds_n, lds_n}, now and then both high
    function automatic logic [1:0] pick_ds(input int unsigned n);
        case (n % 4)
            0:       return 2'b00;
            1:       return 2'b01;
            2:       return 2'b10;
            default: return 2'b11;
        endcase
    endfunction

    function automatic logic [`S16B_ADDR_W:1] region_addr(input logic [2:0] region);
        logic [`S16B_ADDR_W:1] a;
        a = 23'($urandom);
        a[22:20] = region;
        return a;
    endfunction

    task automatic shuffle_inputs();
        cpu_dout     <= 16'($urandom);
        ram_data     <= 16'($urandom);
        rom_data     <= 16'($urandom);
        char_dout    <= 16'($urandom);
        pal_dout     <= 16'($urandom);
        obj_dout     <= 16'($urandom);
        joystick1    <= 8'($urandom);
        joystick2    <= 8'($urandom);
        joystick3    <= 8'($urandom);
        joystick4    <= 8'($urandom);
        joyana1      <= 16'($urandom);
        joyana2      <= 16'($urandom);
        joyana3      <= 16'($urandom);
        joyana4      <= 16'($urandom);
        start_button <= 4'($urandom);
        coin_input   <= 4'($urandom);
        service      <= 1'($urandom);
        dip_test     <= 1'($urandom);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
    endtask

    task automatic run_access(input logic [7:0] game, input logic [`S16B_ADDR_W:1] a,
                              input logic wr, input logic [1:0] ds_n);
        @(posedge clk);
        shuffle_inputs();
        game_id <= game;
        addr    <= a;
        as_n    <= 1'b0;
        rnw     <= !wr;
        uds_n   <= ds_n[1];
        lds_n   <= ds_n[0];
        repeat (4) @(posedge clk);
        check_req = 1'b1;
        wait (!check_req);
        @(posedge clk);
        as_n  <= 1'b1;     // Bus idle
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        rnw   <= 1'b1;
        @(posedge clk);
    endtask

    initial begin
        logic [`S16B_ADDR_W:1] a;
        logic [7:0]            fam_ids [4];
        void'($urandom(91032));
        fam_ids = '{8'h25, 8'h0a, 8'h1a, 8'h10};
        rst = 1'b1;
        game_id = s16b_pkg::GAME_PASSSHT;
        addr = '0;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        {cpu_dout, ram_data, rom_data, char_dout, pal_dout, obj_dout} = '0;
        {joystick1, joystick2, joystick3, joystick4} = '1;
        {joyana1, joyana2, joyana3, joyana4} = '0;
        {start_button, coin_input, service, dip_test} = '1;
        {dipsw_a, dipsw_b} = '1;
        model = '{din: `S16B_BUS_IDLE, raddr: '0, cs: '0, flip: 1'b0, ven: 1'b1, tbank: '0};
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_req = 1'b1;      // Reset values
        wait (!check_req);
        for (int i = 0; i < N_MEM; i++) begin
            case (i % 5)
                0:       a = region_addr(3'd3);
                1:       a = region_addr(3'd4);
                2: begin
                    a = region_addr(3'd5);
                    a[16] = 1'b0;     // Tile RAM
                end
                3: begin
                    a = region_addr(3'd5);
                    a[16] = 1'b1;     // Text RAM
                end
                default: a = region_addr(3'd6);
            endcase
            run_access(pick_game($urandom), a, 1'b0, pick_ds($urandom));
        end
        for (int i = 0; i < N_ROM; i++)
            run_access(pick_game($urandom), region_addr(3'(i % 3)), 1'b0, pick_ds($urandom));
        // Every board family, fixed ids
        for (int i = 0; i < N_FAM; i++)
            run_access(fam_ids[i / 3], region_addr(3'(i % 3)), 1'b0, pick_ds($urandom));
        for (int i = 0; i < N_WR; i++) begin
            if (i < 8) begin
                a = region_addr(3'd7);
                a[13:12] = 2'd0;
            end else begin
                a = region_addr(3'd2);
            end
            run_access(pick_game($urandom), a, 1'b1, (i % 4 == 3) ? 2'b01 : 2'b00);
        end
        for (int i = 0; i < N_IO; i++) begin
            a = region_addr(3'd7);
            if (i % 4 != 0)
                a[9:8] = 2'b10;
            run_access(pick_game($urandom), a, 1'b0, pick_ds($urandom));
        end
        for (int i = 0; i < N_UNMAP; i++)
            run_access(pick_game($urandom), region_addr(3'd0), 1'b1, pick_ds($urandom));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + N_TOTAL * ACCESS_CYCLES + 200));
        $display("Timeout: the accesses did not complete in the expected time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/s16b_pkg.sv
verilog/s16b_region_decode.sv
verilog/s16b_video_ctrl.sv
verilog/s16b_cab_io.sv
verilog/s16b_data_mux.sv
verilog/s16b_main_bus.sv
verification/s16b_props.sv
verification/s16b_tb.sv

// ==== Makefile ====
# Verilator build for the System 16B bus glue

VERILATOR ?= verilator
TOP       ?= s16b_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
